// ==== design/img_pkg.sv ====
package img_pkg;

  // ##################################################
  // Pixel and frame geometry.
  // ##################################################

  localparam int PIX_W = 8;

  typedef logic [PIX_W-1:0] pixel_t;

  localparam int FRAME_COLS = 8;
  localparam int FRAME_ROWS = 6;
  localparam int FRAME_PIXELS = FRAME_COLS * FRAME_ROWS;

  // Counter widths for the window centre position.
  localparam int COL_W = $clog2(FRAME_COLS);
  localparam int ROW_W = $clog2(FRAME_ROWS);

  // ##################################################
  // Stream beats.
  // ##################################################

  typedef struct packed {
    pixel_t pix;
    logic   last;
  } pix_in_t;

  typedef struct packed {
    pixel_t pix;
    logic   last;
  } pix_out_t;

endpackage

// ==== design/filt_pkg.sv ====
package filt_pkg;

  import img_pkg::*;

  // Fill waits for one row plus two pixels, flush adds one row plus one column.
  localparam int FILL_CNT = FRAME_COLS + 1;
  localparam int FLUSH_CNT = FRAME_COLS + 1;
  localparam int SEQ_W = $clog2(FILL_CNT + 1);

  typedef enum logic [1:0] {
    MODE_BYPASS = 2'd0,
    MODE_MEDIAN = 2'd1,
    MODE_SWITCH = 2'd2
  } filt_mode_e;

  typedef enum logic [1:0] {
    WIN_FILL  = 2'd0,
    WIN_RUN   = 2'd1,
    WIN_FLUSH = 2'd2
  } win_state_e;

  typedef struct packed {
    pixel_t top;
    pixel_t mid;
    pixel_t bot;
  } column_t;

  // Nine cells in raster order with p4 at the centre.
  typedef struct packed {
    pixel_t p0;
    pixel_t p1;
    pixel_t p2;
    pixel_t p3;
    pixel_t p4;
    pixel_t p5;
    pixel_t p6;
    pixel_t p7;
    pixel_t p8;
  } window_t;

  typedef struct packed {
    window_t    win;
    logic       valid;
    logic       last;
    filt_mode_e mode;
  } win_beat_t;

  typedef struct packed {
    pixel_t     med;
    logic       valid;
    logic       last;
    filt_mode_e mode;
  } med_res_t;

  typedef struct packed {
    pixel_t wmin;
    pixel_t wmax;
    pixel_t centre;
  } ext_res_t;

  // ##################################################
  // Three-input compare helpers.
  // ##################################################

  function automatic pixel_t min3(pixel_t a, pixel_t b, pixel_t c);
    pixel_t m;
    m = (a < b) ? a : b;
    return (m < c) ? m : c;
  endfunction

  function automatic pixel_t max3(pixel_t a, pixel_t b, pixel_t c);
    pixel_t m;
    m = (a > b) ? a : b;
    return (m > c) ? m : c;
  endfunction

  function automatic pixel_t med3(pixel_t a, pixel_t b, pixel_t c);
    pixel_t lo;
    pixel_t hi;
    pixel_t t;
    lo = (a < b) ? a : b;
    hi = (a > b) ? a : b;
    t = (hi < c) ? hi : c;
    return (lo > t) ? lo : t;
  endfunction

endpackage

// ==== design/line_buffer.sv ====
`timescale 1ns/10ps

module line_buffer import img_pkg::*, filt_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    shift_i,
  input  pixel_t  pix_i,
  output column_t col_o
);

  // Two row-long delay lines sharing one write pointer.
  pixel_t row1_mem [FRAME_COLS];
  pixel_t row2_mem [FRAME_COLS];

  logic [COL_W-1:0] wr_ptr_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q <= '0;
    end else if (shift_i) begin
      if (wr_ptr_q == COL_W'(FRAME_COLS - 1)) begin
        wr_ptr_q <= '0;
      end else begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
    end
  end

  // Second line is fed from the first, so it lags by two rows.
  always_ff @(posedge clk) begin
    if (shift_i) begin
      row1_mem[wr_ptr_q] <= pix_i;
      row2_mem[wr_ptr_q] <= row1_mem[wr_ptr_q];
    end
  end

  always_comb begin
    col_o.top = row2_mem[wr_ptr_q];
    col_o.mid = row1_mem[wr_ptr_q];
    col_o.bot = pix_i;
  end

endmodule

// ==== design/window_pad.sv ====
`timescale 1ns/10ps

module window_pad import img_pkg::*, filt_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       step_en_i,
  input  logic       in_valid_i,
  input  pix_in_t    in_data_i,
  input  filt_mode_e mode_i,
  output logic       in_ready_o,
  output logic       shift_o,
  input  column_t    col_i,
  output win_beat_t  beat_o
);

  win_state_e       state_q;
  logic [SEQ_W-1:0] seq_q;
  logic [ROW_W-1:0] cen_row_q;
  logic [COL_W-1:0] cen_col_q;
  filt_mode_e       mode_q;

  column_t col_l_q;
  column_t col_m_q;
  column_t col_r;
  window_t win_pad;

  logic       accept;
  logic       flushing;
  logic       produce;
  logic       cen_last;
  logic       at_top;
  logic       at_bot;
  logic       at_left;
  logic       at_right;

  window_t    win_q;
  logic       valid_q;
  logic       last_q;
  filt_mode_e bmode_q;

  assign flushing   = (state_q == WIN_FLUSH);
  assign in_ready_o = step_en_i && !flushing;
  assign accept     = in_valid_i && in_ready_o;
  assign shift_o    = accept || (flushing && step_en_i);

  always_comb begin
    case (state_q)
      WIN_FILL:  produce = accept && (seq_q == SEQ_W'(FILL_CNT));
      WIN_RUN:   produce = accept;
      WIN_FLUSH: produce = step_en_i;
      default:   produce = 1'b0;
    endcase
  end

  // ##################################################
  // Fill, run and flush sequencing.
  // ##################################################

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= WIN_FILL;
      seq_q   <= '0;
      mode_q  <= MODE_BYPASS;
    end else begin
      case (state_q)
        WIN_FILL: begin
          if (accept) begin
            // Mode is taken with the first pixel of the frame.
            if (seq_q == '0) begin
              mode_q <= mode_i;
            end
            if (seq_q == SEQ_W'(FILL_CNT)) begin
              state_q <= WIN_RUN;
              seq_q   <= '0;
            end else begin
              seq_q <= seq_q + 1'b1;
            end
          end
        end
        WIN_RUN: begin
          if (accept && in_data_i.last) begin
            state_q <= WIN_FLUSH;
            seq_q   <= '0;
          end
        end
        WIN_FLUSH: begin
          if (step_en_i) begin
            if (seq_q == SEQ_W'(FLUSH_CNT - 1)) begin
              state_q <= WIN_FILL;
              seq_q   <= '0;
            end else begin
              seq_q <= seq_q + 1'b1;
            end
          end
        end
        default: begin
          state_q <= WIN_FILL;
          seq_q   <= '0;
        end
      endcase
    end
  end

  // Position of the centre of the next beat.
  always_ff @(posedge clk) begin
    if (rst) begin
      cen_row_q <= '0;
      cen_col_q <= '0;
    end else if (produce) begin
      if (cen_col_q == COL_W'(FRAME_COLS - 1)) begin
        cen_col_q <= '0;
        if (cen_row_q == ROW_W'(FRAME_ROWS - 1)) begin
          cen_row_q <= '0;
        end else begin
          cen_row_q <= cen_row_q + 1'b1;
        end
      end else begin
        cen_col_q <= cen_col_q + 1'b1;
      end
    end
  end

  // ##################################################
  // Window shift and zero padding.
  // ##################################################

  always_comb begin
    col_r = col_i;
    if (flushing) begin
      col_r.bot = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (shift_o) begin
      col_l_q <= col_m_q;
      col_m_q <= col_r;
    end
  end

  assign at_top   = (cen_row_q == '0);
  assign at_bot   = (cen_row_q == ROW_W'(FRAME_ROWS - 1));
  assign at_left  = (cen_col_q == '0);
  assign at_right = (cen_col_q == COL_W'(FRAME_COLS - 1));
  assign cen_last = at_bot && at_right;

  // Edge flags combine into the nine border cases.
  always_comb begin
    win_pad = '{p0: col_l_q.top, p1: col_m_q.top, p2: col_r.top,
                p3: col_l_q.mid, p4: col_m_q.mid, p5: col_r.mid,
                p6: col_l_q.bot, p7: col_m_q.bot, p8: col_r.bot};
    if (at_top) begin
      win_pad.p0 = '0;
      win_pad.p1 = '0;
      win_pad.p2 = '0;
    end
    if (at_bot) begin
      win_pad.p6 = '0;
      win_pad.p7 = '0;
      win_pad.p8 = '0;
    end
    if (at_left) begin
      win_pad.p0 = '0;
      win_pad.p3 = '0;
      win_pad.p6 = '0;
    end
    if (at_right) begin
      win_pad.p2 = '0;
      win_pad.p5 = '0;
      win_pad.p8 = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (step_en_i) begin
      valid_q <= produce;
    end
  end

  always_ff @(posedge clk) begin
    if (produce) begin
      win_q   <= win_pad;
      last_q  <= cen_last;
      bmode_q <= mode_q;
    end
  end

  assign beat_o = '{win: win_q, valid: valid_q, last: last_q, mode: bmode_q};

endmodule

// ==== design/median_select.sv ====
`timescale 1ns/10ps

module median_select import img_pkg::*, filt_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      step_en_i,
  input  win_beat_t beat_i,
  output med_res_t  res_o
);

  // p0 lands in cells[8], so column j is cells[8-j], cells[5-j], cells[2-j].
  pixel_t [8:0] cells;

  pixel_t     lo_q  [3];
  pixel_t     mid_q [3];
  pixel_t     hi_q  [3];
  logic       s1_valid_q;
  logic       s1_last_q;
  filt_mode_e s1_mode_q;

  pixel_t     med_q;
  logic       s2_valid_q;
  logic       s2_last_q;
  filt_mode_e s2_mode_q;

  assign cells = beat_i.win;

  // ##################################################
  // Stage 1. Sort each column.
  // ##################################################

  always_ff @(posedge clk) begin
    if (step_en_i) begin
      for (int j = 0; j < 3; j++) begin
        lo_q[j]  <= min3(cells[8-j], cells[5-j], cells[2-j]);
        mid_q[j] <= med3(cells[8-j], cells[5-j], cells[2-j]);
        hi_q[j]  <= max3(cells[8-j], cells[5-j], cells[2-j]);
      end
      s1_last_q <= beat_i.last;
      s1_mode_q <= beat_i.mode;
    end
  end

  // ##################################################
  // Stage 2. Median of the three partial results.
  // ##################################################

  always_ff @(posedge clk) begin
    if (step_en_i) begin
      med_q <= med3(max3(lo_q[0], lo_q[1], lo_q[2]),
                    med3(mid_q[0], mid_q[1], mid_q[2]),
                    min3(hi_q[0], hi_q[1], hi_q[2]));
      s2_last_q <= s1_last_q;
      s2_mode_q <= s1_mode_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else if (step_en_i) begin
      s1_valid_q <= beat_i.valid;
      s2_valid_q <= s1_valid_q;
    end
  end

  assign res_o = '{med: med_q, valid: s2_valid_q, last: s2_last_q, mode: s2_mode_q};

endmodule

// ==== design/extrema_detect.sv ====
`timescale 1ns/10ps

module extrema_detect import img_pkg::*, filt_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     step_en_i,
  input  window_t  win_i,
  output ext_res_t res_o
);

  pixel_t [8:0] cells;

  pixel_t cmin_q [3];
  pixel_t cmax_q [3];
  pixel_t centre_q;

  assign cells = win_i;

  // Stage 1 finds the extrema of each column.
  always_ff @(posedge clk) begin
    if (step_en_i) begin
      for (int j = 0; j < 3; j++) begin
        cmin_q[j] <= min3(cells[8-j], cells[5-j], cells[2-j]);
        cmax_q[j] <= max3(cells[8-j], cells[5-j], cells[2-j]);
      end
      centre_q <= win_i.p4;
    end
  end

  // Stage 2 reduces them to the whole-window extrema.
  always_ff @(posedge clk) begin
    if (rst) begin
      res_o <= '0;
    end else if (step_en_i) begin
      res_o.wmin   <= min3(cmin_q[0], cmin_q[1], cmin_q[2]);
      res_o.wmax   <= max3(cmax_q[0], cmax_q[1], cmax_q[2]);
      res_o.centre <= centre_q;
    end
  end

endmodule

// ==== design/noise_switch.sv ====
`timescale 1ns/10ps

module noise_switch import img_pkg::*, filt_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     out_ready_i,
  input  med_res_t med_i,
  input  ext_res_t ext_i,
  output logic     out_valid_o,
  output pix_out_t out_data_o
);

  logic   load;
  logic   is_impulse;
  pixel_t pick;

  // Output register may load when empty or when drained this cycle.
  assign load = ~out_valid_o | out_ready_i;

  // A centre at the window min or max is treated as impulse noise.
  assign is_impulse = (ext_i.centre == ext_i.wmin) || (ext_i.centre == ext_i.wmax);

  always_comb begin
    case (med_i.mode)
      MODE_MEDIAN: pick = med_i.med;
      MODE_SWITCH: pick = is_impulse ? med_i.med : ext_i.centre;
      default:     pick = ext_i.centre;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_o <= 1'b0;
    end else if (load) begin
      out_valid_o <= med_i.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (load && med_i.valid) begin
      out_data_o <= '{pix: pick, last: med_i.last};
    end
  end

endmodule

// ==== design/median_filter_top.sv ====
`timescale 1ns/10ps

module median_filter_top import img_pkg::*, filt_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       in_valid_i,
  output logic       in_ready_o,
  input  pix_in_t    in_data_i,
  input  filt_mode_e mode_i,
  output logic       out_valid_o,
  input  logic       out_ready_i,
  output pix_out_t   out_data_o
);

  logic      step_en;
  logic      shift;
  column_t   col;
  win_beat_t beat;
  med_res_t  med_res;
  ext_res_t  ext_res;

  // Whole pipeline stalls while the output beat waits.
  assign step_en = ~out_valid_o | out_ready_i;

  line_buffer u_line_buffer (
    .clk     (clk),
    .rst     (rst),
    .shift_i (shift),
    .pix_i   (in_data_i.pix),
    .col_o   (col)
  );

  window_pad u_window_pad (
    .clk        (clk),
    .rst        (rst),
    .step_en_i  (step_en),
    .in_valid_i (in_valid_i),
    .in_data_i  (in_data_i),
    .mode_i     (mode_i),
    .in_ready_o (in_ready_o),
    .shift_o    (shift),
    .col_i      (col),
    .beat_o     (beat)
  );

  median_select u_median_select (
    .clk       (clk),
    .rst       (rst),
    .step_en_i (step_en),
    .beat_i    (beat),
    .res_o     (med_res)
  );

  extrema_detect u_extrema_detect (
    .clk       (clk),
    .rst       (rst),
    .step_en_i (step_en),
    .win_i     (beat.win),
    .res_o     (ext_res)
  );

  noise_switch u_noise_switch (
    .clk         (clk),
    .rst         (rst),
    .out_ready_i (out_ready_i),
    .med_i       (med_res),
    .ext_i       (ext_res),
    .out_valid_o (out_valid_o),
    .out_data_o  (out_data_o)
  );

endmodule

// ==== test/median_filter_assert.sv ====
`timescale 1ns/10ps

module median_filter_assert import img_pkg::*; (
  input logic     clk,
  input logic     rst,
  input logic     in_valid_i,
  input logic     in_ready_i,
  input pix_in_t  in_data_i,
  input logic     flush_i,
  input logic     out_valid_i,
  input logic     out_ready_i,
  input pix_out_t out_data_i
);

  // ##################################################
  // Output stream handshake.
  // ##################################################

  // A stalled output beat keeps its data and stays valid.
  a_out_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_data_i))
    else $error("output beat changed while stalled");

  // ##################################################
  // Input side and reset.
  // ##################################################

  // Taking the last pixel of a frame starts the flush and closes the input.
  a_last_flush: assert property (@(posedge clk) disable iff (rst)
    in_valid_i && in_ready_i && in_data_i.last |=> flush_i && !in_ready_i)
    else $error("flush did not start with input closed after the last pixel");

  a_reset_idle: assert property (@(posedge clk)
    rst |=> !out_valid_i && in_ready_i)
    else $error("stream not idle after reset");

endmodule

// ==== test/median_filter_tb.sv ====
`timescale 1ns/10ps

module median_filter_tb import img_pkg::*, filt_pkg::*; ();

  localparam int NUM_FRAMES = 8;
  localparam int TOTAL_PIXELS = NUM_FRAMES * FRAME_PIXELS;
  localparam int CYCLE_LIMIT = 4 * TOTAL_PIXELS + NUM_FRAMES * (FRAME_COLS + 1) + 400;

  typedef enum logic [2:0] {
    PAT_RAMP,
    PAT_CONST,
    PAT_RANDOM,
    PAT_IMPULSE,
    PAT_REPEAT
  } pat_kind_e;

  // Duty is the chance, in eighths, of a gap on in_valid and out_ready.
  typedef struct packed {
    filt_mode_e mode;
    pat_kind_e  kind;
    logic [2:0] duty;
  } frame_cfg_t;

  logic       clk = 1'b0;
  logic       rst;
  logic       in_valid;
  logic       in_ready;
  pix_in_t    in_data;
  filt_mode_e mode_sel;
  logic       out_valid;
  logic       out_ready;
  pix_out_t   out_data;

  frame_cfg_t  frame_tbl [NUM_FRAMES];
  pixel_t      img_mem [TOTAL_PIXELS];
  pixel_t      exp_mem [TOTAL_PIXELS];
  logic [31:0] lfsr_state;
  int          cycle_cnt = 0;

  always #2 clk = ~clk;

  median_filter_top DUT (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .in_data_i   (in_data),
    .mode_i      (mode_sel),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .out_data_o  (out_data)
  );

  bind median_filter_top median_filter_assert u_assert (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (in_valid_i),
    .in_ready_i  (in_ready_o),
    .in_data_i   (in_data_i),
    .flush_i     (u_window_pad.flushing),
    .out_valid_i (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_i  (out_data_o)
  );

  // ##################################################
  // Random source and reference model.
  // ##################################################

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      if (lfsr_state[0]) begin
        lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
      end else begin
        lfsr_state = lfsr_state >> 1;
      end
    end
    return v;
  endfunction

  function automatic logic draw_gap(input logic [2:0] duty);
    if (duty == 3'd0) begin
      return 1'b0;
    end
    return rand_bits(3) < {29'd0, duty};
  endfunction

  // Cells outside the frame read as zero.
  function automatic pixel_t frame_pix(input int base, input int r, input int c);
    if (r < 0 || r >= FRAME_ROWS || c < 0 || c >= FRAME_COLS) begin
      return '0;
    end
    return img_mem[base + r * FRAME_COLS + c];
  endfunction

  task automatic window_stats(input int base, input int r, input int c,
                              output pixel_t med, output pixel_t wmin, output pixel_t wmax);
    pixel_t v [9];
    pixel_t t;
    int     n;
    int     k;
    n = 0;
    for (int dr = -1; dr <= 1; dr++) begin
      for (int dc = -1; dc <= 1; dc++) begin
        v[n] = frame_pix(base, r + dr, c + dc);
        n++;
      end
    end
    // Plain insertion sort.
    for (int i = 1; i < 9; i++) begin
      t = v[i];
      k = i;
      while (k > 0 && v[k-1] > t) begin
        v[k] = v[k-1];
        k--;
      end
      v[k] = t;
    end
    med = v[4];
    wmin = v[0];
    wmax = v[8];
  endtask

  task automatic build_frames();
    int base;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      base = f * FRAME_PIXELS;
      for (int i = 0; i < FRAME_PIXELS; i++) begin
        case (frame_tbl[f].kind)
          PAT_RAMP:   img_mem[base + i] = pixel_t'(i * 5 + 3);
          PAT_CONST:  img_mem[base + i] = 8'd100;
          PAT_RANDOM: img_mem[base + i] = pixel_t'(rand_bits(8));
          PAT_IMPULSE: begin
            if (rand_bits(3) == 32'd0) begin
              img_mem[base + i] = (rand_bits(1) != 32'd0) ? 8'd255 : 8'd0;
            end else begin
              img_mem[base + i] = 8'd90;
            end
          end
          default:    img_mem[base + i] = img_mem[base - FRAME_PIXELS + i];
        endcase
      end
    end
  endtask

  task automatic build_expected();
    pixel_t med;
    pixel_t wmin;
    pixel_t wmax;
    pixel_t cen;
    int     base;
    int     idx;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      base = f * FRAME_PIXELS;
      for (int r = 0; r < FRAME_ROWS; r++) begin
        for (int c = 0; c < FRAME_COLS; c++) begin
          idx = base + r * FRAME_COLS + c;
          cen = img_mem[idx];
          window_stats(base, r, c, med, wmin, wmax);
          case (frame_tbl[f].mode)
            MODE_MEDIAN: exp_mem[idx] = med;
            MODE_SWITCH: exp_mem[idx] = (cen == wmin || cen == wmax) ? med : cen;
            default:     exp_mem[idx] = cen;
          endcase
        end
      end
    end
  endtask

  // ##################################################
  // Compare tasks.
  // ##################################################

  task automatic check_pixel(input pixel_t got, input pixel_t exp, input int idx);
    if (got !== exp) begin
      $display("Fail at %0t ns: output %0d pixel is %0d, expected %0d", $time, idx, got, exp);
      $display("sim failed");
      $fatal(1, "pixel mismatch");
    end
  endtask

  task automatic check_last(input logic got, input logic exp, input int idx);
    if (got !== exp) begin
      $display("Fail at %0t ns: output %0d last is %0b, expected %0b", $time, idx, got, exp);
      $display("sim failed");
      $fatal(1, "last flag mismatch");
    end
  endtask

  always @(posedge clk) begin
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: the output stream did not finish within %0d cycles", CYCLE_LIMIT);
      $display("sim failed");
      $fatal(1, "cycle limit reached");
    end else begin
      cycle_cnt <= cycle_cnt + 1;
    end
  end

  // ##################################################
  // Stimulus and response loop.
  // ##################################################

  initial begin
    frame_cfg_t cfg;
    int         in_idx;
    int         out_idx;
    rst = 1'b1;
    in_valid = 1'b0;
    in_data = '0;
    mode_sel = MODE_BYPASS;
    out_ready = 1'b0;
    lfsr_state = 32'd70927;
    in_idx = 0;
    out_idx = 0;

    frame_tbl[0] = '{mode: MODE_BYPASS, kind: PAT_RAMP, duty: 3'd0};
    frame_tbl[1] = '{mode: MODE_MEDIAN, kind: PAT_CONST, duty: 3'd0};
    frame_tbl[2] = '{mode: MODE_MEDIAN, kind: PAT_RANDOM, duty: 3'd0};
    frame_tbl[3] = '{mode: MODE_MEDIAN, kind: PAT_RANDOM, duty: 3'd0};
    frame_tbl[4] = '{mode: MODE_SWITCH, kind: PAT_IMPULSE, duty: 3'd0};
    frame_tbl[5] = '{mode: MODE_MEDIAN, kind: PAT_REPEAT, duty: 3'd3};
    frame_tbl[6] = '{mode: MODE_SWITCH, kind: PAT_IMPULSE, duty: 3'd2};
    frame_tbl[7] = '{mode: MODE_BYPASS, kind: PAT_RANDOM, duty: 3'd3};
    build_frames();
    build_expected();

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    while (out_idx < TOTAL_PIXELS) begin
      @(negedge clk);
      if (in_idx < TOTAL_PIXELS) begin
        cfg = frame_tbl[in_idx / FRAME_PIXELS];
        in_valid = !draw_gap(cfg.duty);
        in_data.pix = img_mem[in_idx];
        in_data.last = ((in_idx % FRAME_PIXELS) == FRAME_PIXELS - 1);
        mode_sel = cfg.mode;
      end else begin
        in_valid = 1'b0;
        in_data = '0;
      end
      cfg = frame_tbl[out_idx / FRAME_PIXELS];
      out_ready = !draw_gap(cfg.duty);

      // Handshakes resolve on the next rising edge.
      #1;
      if (in_valid && in_ready) begin
        in_idx++;
      end
      if (out_valid && out_ready) begin
        check_pixel(out_data.pix, exp_mem[out_idx], out_idx);
        check_last(out_data.last, (out_idx % FRAME_PIXELS) == FRAME_PIXELS - 1, out_idx);
        out_idx++;
      end
    end

    // Every expected beat is taken, so the stream must now stay quiet.
    repeat (8) begin
      @(negedge clk);
      in_valid = 1'b0;
      out_ready = 1'b1;
      if (out_valid) begin
        $display("Error: the DUT produced more output beats than pixels it received");
        $display("sim failed");
        $fatal(1, "extra output beat");
      end
    end

    $display("sim passed");
    $finish;
  end

endmodule

// ==== flist.f ====
design/img_pkg.sv
design/filt_pkg.sv
design/line_buffer.sv
design/window_pad.sv
design/median_select.sv
design/extrema_detect.sv
design/noise_switch.sv
design/median_filter_top.sv
test/median_filter_assert.sv
test/median_filter_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the median filter testbench with Verilator and run it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module median_filter_tb \
  -f flist.f \
  -o sim_median_filter

./obj_dir/sim_median_filter
